//--- Makefile
# Verilator build and run of the DAC transmit path testbench

VERILATOR ?= verilator
TOP       ?= transmit_top_tb
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/awg_buffer.sv
// ==========================================================================
// arbitrary waveform buffer: per-channel sample memory loaded from a
// write stream, replayed in bursts with a trigger on each channel 0 frame
// ==========================================================================
`timescale 1ns/10ps
`default_nettype none

module awg_buffer (
  input  logic                ps_clk,
  input  logic                ps_reset,
  input  tx_pkg::cfg_word_t   cfg,
  input  logic                cfg_valid,
  input  tx_pkg::awg_wr_t     awg_wr,
  input  logic                awg_wr_valid,
  output logic                awg_wr_ready,
  input  logic                start,
  output tx_pkg::sample_vec_t samples,
  output logic                trigger,
  output logic                busy
);

  logic [tx_pkg::channels-1:0] active;
  logic                        frame_start;
  logic                        wr_fire;
  logic                        burst_write;
  logic                        launch;

  assign busy         = |active;
  assign awg_wr_ready = ~busy;
  assign wr_fire      = awg_wr_valid && awg_wr_ready;
  assign burst_write  = cfg_valid && (cfg.target == tx_pkg::tgt_burst_len);
  assign launch       = start && !busy;

  for (genvar ch = 0; ch < tx_pkg::channels; ch++) begin : g_chan
    tx_pkg::sample_t   mem [tx_pkg::awg_depth];
    tx_pkg::awg_addr_t wr_ptr;
    tx_pkg::awg_addr_t rd_addr;
    tx_pkg::awg_len_t  frame_len;
    logic [31:0]       burst_len;
    logic [31:0]       rep_cnt;
    logic              playing;
    logic              wr_here;
    logic              frame_end;
    logic              burst_end;
    tx_pkg::sample_t   rd_data;

    assign wr_here   = wr_fire && (awg_wr.channel == 1'(ch));
    assign frame_end = ({1'b0, rd_addr} + 1'b1) == frame_len;
    assign burst_end = (rep_cnt + 32'd1) == burst_len;

    always_ff @(posedge ps_clk) begin
      if (wr_here) begin
        mem[wr_ptr] <= awg_wr.sample;
      end
    end

    // last closes the frame and rewinds for the next load
    always_ff @(posedge ps_clk) begin
      if (ps_reset) begin
        wr_ptr    <= '0;
        frame_len <= '0;
      end else if (wr_here) begin
        if (awg_wr.last) begin
          wr_ptr    <= '0;
          frame_len <= {1'b0, wr_ptr} + 1'b1;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
    end

    always_ff @(posedge ps_clk) begin
      if (ps_reset) begin
        burst_len <= 32'd1;
      end else if (burst_write && (cfg.channel == 1'(ch))) begin
        burst_len <= cfg.value;
      end
    end

    // empty frames never start
    always_ff @(posedge ps_clk) begin
      if (ps_reset) begin
        playing <= 1'b0;
        rd_addr <= '0;
        rep_cnt <= '0;
      end else if (launch && (frame_len != '0)) begin
        playing <= 1'b1;
        rd_addr <= '0;
        rep_cnt <= '0;
      end else if (playing) begin
        if (frame_end) begin
          rd_addr <= '0;
          rep_cnt <= rep_cnt + 32'd1;
          if (burst_end) begin
            playing <= 1'b0;
          end
        end else begin
          rd_addr <= rd_addr + 1'b1;
        end
      end
    end

    // memory read doubles as the output register and gives zero while idle
    always_ff @(posedge ps_clk) begin
      rd_data <= playing ? mem[rd_addr] : '0;
    end

    assign samples[ch] = rd_data;
    assign active[ch]  = playing;

    // only channel 0 frames mark the trigger
    if (ch == 0) begin : g_trig
      assign frame_start = playing && (rd_addr == '0);
    end
  end

  // lines up with the first sample of each channel 0 repetition
  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      trigger <= 1'b0;
    end else begin
      trigger <= frame_start;
    end
  end

endmodule

`default_nettype wire

//--- hw/sample_scaler.sv
// ==========================================================================
// prescaler: per channel fixed point gain with saturation to the
// signed sample range, registered into the DAC frame
// ==========================================================================
`timescale 1ns/10ps
`default_nettype none

module sample_scaler (
  input  logic                ps_clk,
  input  logic                ps_reset,
  input  tx_pkg::cfg_word_t   cfg,
  input  logic                cfg_valid,
  input  tx_pkg::sample_vec_t samples,
  input  logic                trigger,
  output tx_pkg::dac_frame_t  dac_out
);

  logic                scale_write;
  tx_pkg::sample_vec_t sat_samples;

  assign scale_write = cfg_valid && (cfg.target == tx_pkg::tgt_scale);

  for (genvar ch = 0; ch < tx_pkg::channels; ch++) begin : g_chan
    logic        [tx_pkg::scale_width-1:0]  gain;
    logic signed [tx_pkg::scaled_width-1:0] prod;
    logic signed [tx_pkg::scaled_width-1:0] shifted;
    logic                                   fits;

    always_ff @(posedge ps_clk) begin
      if (ps_reset) begin
        gain <= tx_pkg::scale_one;
      end else if (scale_write && (cfg.channel == 1'(ch))) begin
        gain <= cfg.value[tx_pkg::scale_width-1:0];
      end
    end

    // gain gets a zero sign bit so the multiply stays signed
    assign prod    = samples[ch] * $signed({1'b0, gain});
    assign shifted = prod >>> tx_pkg::scale_frac_bits;

    // in range when everything above the sample msb copies the sign
    assign fits = (&shifted[tx_pkg::scaled_width-1:tx_pkg::sample_width-1]) ||
                  !(|shifted[tx_pkg::scaled_width-1:tx_pkg::sample_width-1]);

    assign sat_samples[ch] = fits ? shifted[tx_pkg::sample_width-1:0] :
                             shifted[tx_pkg::scaled_width-1] ? tx_pkg::sample_min :
                             tx_pkg::sample_max;
  end

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      dac_out <= '0;
    end else begin
      dac_out.samples <= sat_samples;
      dac_out.trigger <= trigger;
    end
  end

endmodule

`default_nettype wire

//--- hw/source_mux.sv
// ==========================================================================
// source mux: per channel choice of waveform buffer, triangle or silence,
// with the buffer trigger delayed alongside
// ==========================================================================
`timescale 1ns/10ps
`default_nettype none

module source_mux (
  input  logic                ps_clk,
  input  logic                ps_reset,
  input  tx_pkg::cfg_word_t   cfg,
  input  logic                cfg_valid,
  input  tx_pkg::sample_vec_t awg_samples,
  input  tx_pkg::sample_vec_t tri_samples,
  input  logic                awg_trigger,
  output tx_pkg::sample_vec_t samples,
  output logic                trigger
);

  logic                sel_write;
  tx_pkg::sample_vec_t mux_next;

  assign sel_write = cfg_valid && (cfg.target == tx_pkg::tgt_source_sel);

  for (genvar ch = 0; ch < tx_pkg::channels; ch++) begin : g_chan
    tx_pkg::source_sel_e sel;

    always_ff @(posedge ps_clk) begin
      if (ps_reset) begin
        sel <= tx_pkg::src_zero;
      end else if (sel_write && (cfg.channel == 1'(ch))) begin
        sel <= tx_pkg::source_sel_e'(cfg.value[1:0]);
      end
    end

    // unused code 3 also silences the channel
    always_comb begin
      case (sel)
        tx_pkg::src_awg: mux_next[ch] = awg_samples[ch];
        tx_pkg::src_tri: mux_next[ch] = tri_samples[ch];
        default:         mux_next[ch] = '0;
      endcase
    end
  end

  always_ff @(posedge ps_clk) begin
    samples <= mux_next;
  end

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      trigger <= 1'b0;
    end else begin
      trigger <= awg_trigger;
    end
  end

endmodule

`default_nettype wire

//--- hw/transmit_top.sv
// ==========================================================================
// DAC transmit path: waveform buffer and triangle sources through the
// source mux and prescaler, all configured from one shared stream
// ==========================================================================
`timescale 1ns/10ps
`default_nettype none

module transmit_top (
  input  logic               ps_clk,
  input  logic               ps_reset,
  input  tx_pkg::cfg_word_t  cfg,
  input  logic               cfg_valid,
  input  tx_pkg::awg_wr_t    awg_wr,
  input  logic               awg_wr_valid,
  output logic               awg_wr_ready,
  input  logic               start,
  output tx_pkg::dac_frame_t dac_out,
  output logic               busy
);

  tx_pkg::sample_vec_t tri_samples;
  tx_pkg::sample_vec_t awg_samples;
  tx_pkg::sample_vec_t mux_samples;
  logic                awg_trigger;
  logic                mux_trigger;

  tri_wave_gen i_tri_wave_gen (
    .ps_clk    (ps_clk),
    .ps_reset  (ps_reset),
    .cfg       (cfg),
    .cfg_valid (cfg_valid),
    .samples   (tri_samples)
  );

  awg_buffer i_awg_buffer (
    .ps_clk       (ps_clk),
    .ps_reset     (ps_reset),
    .cfg          (cfg),
    .cfg_valid    (cfg_valid),
    .awg_wr       (awg_wr),
    .awg_wr_valid (awg_wr_valid),
    .awg_wr_ready (awg_wr_ready),
    .start        (start),
    .samples      (awg_samples),
    .trigger      (awg_trigger),
    .busy         (busy)
  );

  // one register stage each in the mux and the prescaler
  source_mux i_source_mux (
    .ps_clk      (ps_clk),
    .ps_reset    (ps_reset),
    .cfg         (cfg),
    .cfg_valid   (cfg_valid),
    .awg_samples (awg_samples),
    .tri_samples (tri_samples),
    .awg_trigger (awg_trigger),
    .samples     (mux_samples),
    .trigger     (mux_trigger)
  );

  sample_scaler i_sample_scaler (
    .ps_clk    (ps_clk),
    .ps_reset  (ps_reset),
    .cfg       (cfg),
    .cfg_valid (cfg_valid),
    .samples   (mux_samples),
    .trigger   (mux_trigger),
    .dac_out   (dac_out)
  );

endmodule

`default_nettype wire

//--- hw/tri_wave_gen.sv
// ==========================================================================
// triangle wave source: a phase accumulator per channel, folded into a
// signed ramp that rises over half a period and falls over the other
// ==========================================================================
`timescale 1ns/10ps
`default_nettype none

module tri_wave_gen (
  input  logic                ps_clk,
  input  logic                ps_reset,
  input  tx_pkg::cfg_word_t   cfg,
  input  logic                cfg_valid,
  output tx_pkg::sample_vec_t samples
);

  logic                inc_write;
  tx_pkg::sample_vec_t fold_next;

  assign inc_write = cfg_valid && (cfg.target == tx_pkg::tgt_tri_phase_inc);

  for (genvar ch = 0; ch < tx_pkg::channels; ch++) begin : g_chan
    logic [tx_pkg::phase_bits-1:0] phase;
    logic [tx_pkg::phase_bits-1:0] phase_inc;
    tx_pkg::sample_t               rise;

    // a new increment restarts the ramp at its bottom
    always_ff @(posedge ps_clk) begin
      if (ps_reset) begin
        phase     <= '0;
        phase_inc <= '0;
      end else if (inc_write && (cfg.channel == 1'(ch))) begin
        phase     <= '0;
        phase_inc <= cfg.value;
      end else begin
        phase <= phase + phase_inc;
      end
    end

    // offset binary of the half period, msb flipped to get two's complement
    assign rise = {~phase[tx_pkg::phase_bits-2],
                   phase[tx_pkg::phase_bits-3 -: tx_pkg::sample_width-1]};

    // second half mirrors the first
    assign fold_next[ch] = phase[tx_pkg::phase_bits-1] ? ~rise : rise;
  end

  always_ff @(posedge ps_clk) begin
    samples <= fold_next;
  end

endmodule

`default_nettype wire

//--- hw/tx_pkg.sv
// ==========================================================================
// transmit path package: sizes, config stream format and sample
// containers shared by the DAC transmit blocks
// ==========================================================================
`default_nettype none

package tx_pkg;

  localparam int channels        = 2;
  localparam int sample_width    = 16;
  localparam int phase_bits      = 32;
  localparam int scale_width     = 18;
  localparam int scale_frac_bits = 16;
  localparam int awg_depth       = 64;

  localparam int awg_addr_bits = $clog2(awg_depth);
  // signed sample times unsigned gain with its sign bit
  localparam int scaled_width  = sample_width + scale_width + 1;

  localparam logic [scale_width-1:0] scale_one = scale_width'(1) << scale_frac_bits;
  localparam logic [sample_width-1:0] sample_max = {1'b0, {(sample_width-1){1'b1}}};
  localparam logic [sample_width-1:0] sample_min = {1'b1, {(sample_width-1){1'b0}}};

  typedef logic [awg_addr_bits-1:0] awg_addr_t;
  typedef logic [awg_addr_bits:0]   awg_len_t;

  typedef enum logic [2:0] {
    tgt_tri_phase_inc = 3'd0,
    tgt_scale         = 3'd1,
    tgt_source_sel    = 3'd2,
    tgt_burst_len     = 3'd3
  } cfg_target_e;

  typedef enum logic [1:0] {
    src_awg  = 2'd0,
    src_tri  = 2'd1,
    src_zero = 2'd2
  } source_sel_e;

  typedef struct packed {
    cfg_target_e target;
    logic        channel;
    logic [31:0] value;
  } cfg_word_t;

  typedef logic signed [sample_width-1:0] sample_t;

  typedef struct packed {
    logic    channel;
    sample_t sample;
    logic    last;
  } awg_wr_t;

  typedef sample_t [channels-1:0] sample_vec_t;

  typedef struct packed {
    sample_vec_t samples;
    logic        trigger;
  } dac_frame_t;

endpackage

`default_nettype wire

//--- tb.f
hw/tx_pkg.sv
hw/tri_wave_gen.sv
hw/awg_buffer.sv
hw/source_mux.sv
hw/sample_scaler.sv
hw/transmit_top.sv
verif/transmit_top_chk.sv
verif/transmit_top_tb.sv

//--- verif/transmit_top_chk.sv
// ==========================================================================
// transmit path checker: write handshake, reset and trigger properties
// ==========================================================================
`timescale 1ns/10ps
`default_nettype none

module transmit_top_chk (
  input logic               ps_clk,
  input logic               ps_reset,
  input logic               awg_wr_ready,
  input logic               busy,
  input tx_pkg::dac_frame_t dac_out
);

  // the buffer takes no writes while it plays
  ready_low_while_busy: assert property (
    @(posedge ps_clk) disable iff (ps_reset) busy |-> !awg_wr_ready
  ) else $error("write ready was high while playback ran");

  // first cycle out of reset
  zero_after_reset: assert property (
    @(posedge ps_clk) $fell(ps_reset) |-> (dac_out == '0)
  ) else $error("dac output was not cleared after reset");

  trigger_only_when_busy: assert property (
    @(posedge ps_clk) disable iff (ps_reset) $rose(dac_out.trigger) |-> busy
  ) else $error("frame trigger rose while playback was idle");

endmodule

`default_nettype wire

//--- verif/transmit_top_tb.sv
// ==========================================================================
// DAC transmit path testbench: waveform playback, triangle, gain and
// silence checked each cycle against a cycle based model
// ==========================================================================
`timescale 1ns/10ps
`default_nettype none

module transmit_top_tb;

  localparam int timeout_cycles = 2000;
  localparam int burst_reps     = 3;
  localparam int len0           = 8;
  localparam int len1           = 5;

  logic               ps_clk;
  logic               ps_reset;
  tx_pkg::cfg_word_t  cfg;
  logic               cfg_valid;
  tx_pkg::awg_wr_t    awg_wr;
  logic               awg_wr_valid;
  logic               awg_wr_ready;
  logic               start;
  tx_pkg::dac_frame_t dac_out;
  logic               busy;

  // shadow state of the model
  tx_pkg::sample_t                frame [tx_pkg::channels][tx_pkg::awg_depth];
  int                             frame_len [tx_pkg::channels];
  int                             wr_ptr [tx_pkg::channels];
  int                             burst_len [tx_pkg::channels];
  logic [31:0]                    phase [tx_pkg::channels];
  logic [31:0]                    phase_inc [tx_pkg::channels];
  logic [tx_pkg::scale_width-1:0] gain [tx_pkg::channels];
  tx_pkg::source_sel_e            sel [tx_pkg::channels];
  tx_pkg::sample_vec_t            tri_reg;
  tx_pkg::sample_vec_t            awg_reg;
  tx_pkg::sample_vec_t            mux_reg;
  logic                           awg_trig;
  logic                           mux_trig;
  tx_pkg::dac_frame_t             exp_out;
  logic                           model_live = 1'b0;
  int                             play_t = -1;
  int                             play_total = 0;
  int                             errors = 0;
  int                             checks = 0;
  int                             cycles = 0;

  transmit_top i_transmit_top (
    .ps_clk       (ps_clk),
    .ps_reset     (ps_reset),
    .cfg          (cfg),
    .cfg_valid    (cfg_valid),
    .awg_wr       (awg_wr),
    .awg_wr_valid (awg_wr_valid),
    .awg_wr_ready (awg_wr_ready),
    .start        (start),
    .dac_out      (dac_out),
    .busy         (busy)
  );

  bind transmit_top transmit_top_chk i_transmit_top_chk (.*);

  initial begin
    ps_clk = 1'b0;
    forever #20 ps_clk = ~ps_clk;
  end

  // ramp from the top 17 phase bits, falling in the second half
  function automatic tx_pkg::sample_t fold(logic [31:0] p);
    int rise;
    rise = int'(p[30:15]) - 32768;
    if (p[31]) begin
      rise = -rise - 1;
    end
    return tx_pkg::sample_t'(rise);
  endfunction

  function automatic tx_pkg::sample_t scale_sat(tx_pkg::sample_t s,
                                                logic [tx_pkg::scale_width-1:0] g);
    longint prod;
    prod = (longint'(s) * longint'(g)) >>> tx_pkg::scale_frac_bits;
    if (prod > 32767) begin
      prod = 32767;
    end else if (prod < -32768) begin
      prod = -32768;
    end
    return tx_pkg::sample_t'(prod);
  endfunction

  // expected dac_out for the mux stage contents and the current gains
  function automatic tx_pkg::dac_frame_t expected_frame(tx_pkg::sample_vec_t s, logic trig);
    tx_pkg::dac_frame_t f;
    for (int ch = 0; ch < tx_pkg::channels; ch++) begin
      f.samples[ch] = scale_sat(s[ch], gain[ch]);
    end
    f.trigger = trig;
    return f;
  endfunction

  function automatic void reset_model();
    for (int ch = 0; ch < tx_pkg::channels; ch++) begin
      phase[ch]     = '0;
      phase_inc[ch] = '0;
      gain[ch]      = tx_pkg::scale_width'(1 << tx_pkg::scale_frac_bits);
      sel[ch]       = tx_pkg::src_zero;
      burst_len[ch] = 1;
      frame_len[ch] = 0;
      wr_ptr[ch]    = 0;
    end
    tri_reg    = '0;
    awg_reg    = '0;
    mux_reg    = '0;
    awg_trig   = 1'b0;
    mux_trig   = 1'b0;
    exp_out    = '0;
    play_t     = -1;
    play_total = 0;
    model_live = 1'b0;
  endfunction

  always @(posedge ps_clk) begin : model_step
    logic was_busy;
    int   wch;
    if (ps_reset) begin
      reset_model();
    end else begin
      was_busy   = (play_t >= 0);
      model_live = 1'b1;
      // later stages first, they take last cycle's values
      exp_out  = expected_frame(mux_reg, mux_trig);
      mux_trig = awg_trig;
      for (int ch = 0; ch < tx_pkg::channels; ch++) begin
        case (sel[ch])
          tx_pkg::src_awg: mux_reg[ch] = awg_reg[ch];
          tx_pkg::src_tri: mux_reg[ch] = tri_reg[ch];
          default:         mux_reg[ch] = '0;
        endcase
        tri_reg[ch] = fold(phase[ch]);
        awg_reg[ch] = '0;
        if (play_t >= 0 && frame_len[ch] != 0 && play_t < burst_len[ch] * frame_len[ch]) begin
          awg_reg[ch] = frame[ch][play_t % frame_len[ch]];
        end
        if (cfg_valid && cfg.target == tx_pkg::tgt_tri_phase_inc &&
            int'(cfg.channel) == ch) begin
          phase[ch]     = '0;
          phase_inc[ch] = cfg.value;
        end else begin
          phase[ch] = phase[ch] + phase_inc[ch];
        end
      end
      awg_trig = play_t >= 0 && frame_len[0] != 0 && play_t % frame_len[0] == 0 &&
                 play_t < burst_len[0] * frame_len[0];
      if (play_t >= 0) begin
        play_t++;
        if (play_t >= play_total) begin
          play_t = -1;
        end
      end
      // start during playback is dropped
      if (start && !was_busy) begin
        play_total = 0;
        for (int ch = 0; ch < tx_pkg::channels; ch++) begin
          if (burst_len[ch] * frame_len[ch] > play_total) begin
            play_total = burst_len[ch] * frame_len[ch];
          end
        end
        if (play_total > 0) begin
          play_t = 0;
        end
      end
      if (awg_wr_valid && !was_busy) begin
        wch = int'(awg_wr.channel);
        frame[wch][wr_ptr[wch]] = awg_wr.sample;
        if (awg_wr.last) begin
          frame_len[wch] = wr_ptr[wch] + 1;
          wr_ptr[wch]    = 0;
        end else begin
          wr_ptr[wch] = (wr_ptr[wch] + 1) % tx_pkg::awg_depth;
        end
      end
      if (cfg_valid) begin
        case (cfg.target)
          tx_pkg::tgt_scale:      gain[cfg.channel] = cfg.value[tx_pkg::scale_width-1:0];
          tx_pkg::tgt_source_sel: sel[cfg.channel] = tx_pkg::source_sel_e'(cfg.value[1:0]);
          tx_pkg::tgt_burst_len:  burst_len[cfg.channel] = int'(cfg.value);
          default: ;
        endcase
      end
    end
  end

  always @(negedge ps_clk) begin
    if (model_live) begin
      checks++;
      assert (dac_out === exp_out) else begin
        errors++;
        $display("** Error: dac_out is %h, expected %h", dac_out, exp_out);
      end
      assert (busy === (play_t >= 0)) else begin
        errors++;
        $display("** Error: busy is %h, expected %h", busy, play_t >= 0);
      end
      assert (awg_wr_ready === (play_t < 0)) else begin
        errors++;
        $display("** Error: awg_wr_ready is %h, expected %h", awg_wr_ready, play_t < 0);
      end
    end
  end

  // several times the longest run of all the tests together
  always @(posedge ps_clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic send_cfg(tx_pkg::cfg_target_e target, int ch, logic [31:0] value);
    cfg.target  = target;
    cfg.channel = ch[0];
    cfg.value   = value;
    cfg_valid   = 1'b1;
    @(negedge ps_clk);
    cfg_valid = 1'b0;
  endtask

  task automatic write_frame(int ch, int len);
    for (int i = 0; i < len; i++) begin
      awg_wr.channel = ch[0];
      awg_wr.sample  = tx_pkg::sample_t'($urandom);
      awg_wr.last    = (i == len - 1);
      awg_wr_valid   = 1'b1;
      @(negedge ps_clk);
    end
    awg_wr_valid = 1'b0;
  endtask

  initial begin : stimulus
    int seed_value;
    int busy_cycles;
    seed_value   = $urandom(4375);
    ps_reset     = 1'b1;
    cfg          = '0;
    cfg_valid    = 1'b0;
    awg_wr       = '0;
    awg_wr_valid = 1'b0;
    start        = 1'b0;
    repeat (2) @(posedge ps_clk);
    @(negedge ps_clk);
    ps_reset = 1'b0;
    assert (dac_out === '0 && busy === 1'b0) else begin
      errors++;
      $display("** Error: dac_out is %h, busy is %h after reset, expected 0", dac_out, busy);
    end

    // burst playback of two frames of different length
    write_frame(0, len0);
    write_frame(1, len1);
    for (int ch = 0; ch < tx_pkg::channels; ch++) begin
      send_cfg(tx_pkg::tgt_burst_len, ch, burst_reps);
      send_cfg(tx_pkg::tgt_source_sel, ch, 32'(tx_pkg::src_awg));
    end
    start = 1'b1;
    @(negedge ps_clk);
    start        = 1'b0;
    busy_cycles  = 0;
    awg_wr       = '{channel: 1'b0, sample: 16'h1234, last: 1'b1};
    while (busy) begin
      busy_cycles++;
      awg_wr_valid = (busy_cycles >= 4 && busy_cycles < 8);
      if (awg_wr_valid) begin
        assert (!awg_wr_ready) else begin
          errors++;
          $display("a write was accepted during playback");
        end
      end
      @(negedge ps_clk);
    end
    awg_wr_valid = 1'b0;
    assert (busy_cycles == burst_reps * len0) else begin
      errors++;
      $display("** Error: busy was high for %h cycles, expected %h",
               busy_cycles, burst_reps * len0);
    end
    repeat (4) @(negedge ps_clk);

    // triangle sources with random increments
    send_cfg(tx_pkg::tgt_source_sel, 0, 32'(tx_pkg::src_tri));
    send_cfg(tx_pkg::tgt_source_sel, 1, 32'(tx_pkg::src_tri));
    send_cfg(tx_pkg::tgt_tri_phase_inc, 0, $urandom >> 4);
    send_cfg(tx_pkg::tgt_tri_phase_inc, 1, $urandom >> 8);
    repeat (64) @(negedge ps_clk);

    // gains above and below 1.0
    send_cfg(tx_pkg::tgt_scale, 0, $urandom_range(262143, 65536));
    send_cfg(tx_pkg::tgt_scale, 1, $urandom_range(65535, 0));
    repeat (48) @(negedge ps_clk);

    // silence on channel 1 only
    send_cfg(tx_pkg::tgt_source_sel, 1, 32'(tx_pkg::src_zero));
    repeat (24) @(negedge ps_clk);
    assert (dac_out.samples[1] === '0) else begin
      errors++;
      $display("** Error: dac_out.samples[1] is %h, expected 0", dac_out.samples[1]);
    end
    repeat (4) @(negedge ps_clk);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
